// ==== Bender.yml ====
package:
  name: controlUnit

export_include_dirs:
  - source

sources:
  - source/controlPkg.sv
  - source/instrDecoder.sv
  - source/cycleSequencer.sv
  - source/controlWordGen.sv
  - source/controlUnit.sv
  - target: simulation
    files:
      - sim/controlUnit_checker.sv
      - sim/controlUnitTb.sv

// ==== controlUnit.f ====
+incdir+source
source/controlPkg.sv
source/instrDecoder.sv
source/cycleSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
sim/controlUnit_checker.sv
sim/controlUnitTb.sv

// ==== sim/controlUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "controlUnit_macros.svh"

module controlUnitTb;

    localparam int directedCount = 12;
    localparam int randomCount   = 40;
    localparam int instrCount    = directedCount + randomCount;

    typedef struct packed {
        logic [3:0]           period;
        logic                 resetOut;
        controlPkg::ctrlWordT word;
    } expectT;

    logic                    clk;
    logic                    rstN;
    logic [`OPCODE_W-1:0]    opcode;
    controlPkg::instrLowU    instrLow;
    controlPkg::ctrlWordT    ctrl;
    logic                    resetOut;

    logic [`OPCODE_W-1:0]    opList [instrCount];
    controlPkg::instrLowU    lowList [instrCount];
    int                      fillIdx = 0;
    int                      cycleNum = 0;
    int                      checkCount = 0;
    int                      errorCount = 0;

    controlUnit uut (
        .clk      (clk),
        .rstN     (rstN),
        .opcode   (opcode),
        .instrLow (instrLow),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycleNum <= cycleNum + 1;

    // Expected period and first execute word from the instruction rules
    function automatic expectT expectFor(
        input logic [`OPCODE_W-1:0] op,
        input logic [`FUNCT_W-1:0]  fn
    );
        expectT e;
        logic   unknown;
        e = '0;
        e.period = 4'd8;
        unknown = 1'b0;
        if (op == 6'h00) begin
            case (fn)
                6'h0D: begin
                    e.period = 4'd9;
                    e.word.pcWrite  = 1'b1;
                    e.word.aluOp    = controlPkg::aluSub;
                    e.word.aluSrcA  = 2'd1;
                    e.word.aluSrcB  = 2'd1;
                    e.word.pcSource = 2'd1;
                end
                6'h13: begin
                    e.period = 4'd9;
                    e.word.pcWrite  = 1'b1;
                    e.word.pcSource = 2'd3;
                end
                6'h20, 6'h24, 6'h18, 6'h1A, 6'h08, 6'h10, 6'h12, 6'h00, 6'h04,
                6'h2A, 6'h03, 6'h07, 6'h02, 6'h22, 6'h05: ;
                default: unknown = 1'b1;
            endcase
        end else if (op == 6'h3F) begin
            e.resetOut = 1'b1;
            e.word.regWrite = 1'b1;
            e.word.dataSrc  = 3'd4;
        end else begin
            case (op)
                6'h08, 6'h09, 6'h04, 6'h05, 6'h06, 6'h07, 6'h01, 6'h20, 6'h21,
                6'h0F, 6'h23, 6'h28, 6'h29, 6'h0A, 6'h2B, 6'h02, 6'h03: ;
                default: unknown = 1'b1;
            endcase
        end
        if (unknown) begin
            e.word.epcWrite = 1'b1;
            e.word.exCause  = 2'd1;
        end
        return e;
    endfunction

    task automatic addInstr(input logic [`OPCODE_W-1:0] op, input logic [`FUNCT_W-1:0] fn);
        opList[fillIdx] = op;
        lowList[fillIdx].rType.rd    = 5'd3;
        lowList[fillIdx].rType.shamt = 5'd0;
        lowList[fillIdx].rType.funct = fn;
        fillIdx++;
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] got);
        checkCount++;
        assert (got === expected)
        else begin
            errorCount++;
            $display("error at time %0t: %s expected %0h got %0h", $time, name, expected, got);
        end
    endtask

    task automatic waitForIrWrite();
        do begin
            @(negedge clk);
        end while (ctrl.irWrite !== 1'b1);
    endtask

    // Next instruction goes in one cycle after each IR write
    initial begin : driveInstr
        int k;
        for (k = 0; k < instrCount; k++) begin
            waitForIrWrite();
            @(posedge clk);
            opcode   <= opList[k];
            instrLow <= lowList[k];
        end
    end

    initial begin : watchdog
        #((instrCount * 10 + 20) * 10);
        $display("timeout: the instruction sequence did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin : compareSeq
        integer      seed;
        logic [31:0] randWord;
        int          i;
        int          releaseCycle;
        int          lastIr;
        expectT      want;
        seed = 67349;
        rstN     <= 1'b0;
        opcode   <= '0;
        instrLow <= '0;
        addInstr(6'h00, 6'h20);
        addInstr(6'h23, 6'h00);
        addInstr(6'h02, 6'h00);
        addInstr(6'h00, 6'h0D);
        addInstr(6'h00, 6'h13);
        addInstr(6'h00, 6'h3F);
        addInstr(6'h3E, 6'h00);
        addInstr(6'h3F, 6'h11);
        addInstr(6'h00, 6'h00);
        addInstr(6'h08, 6'h04);
        addInstr(6'h04, 6'h00);
        addInstr(6'h2B, 6'h08);
        // Half of the random codes are R-type
        for (i = directedCount; i < instrCount; i++) begin
            randWord = $random(seed);
            opList[i] = randWord[31] ? 6'h00 : randWord[5:0];
            lowList[i].imm = randWord[21:6];
        end

        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            checkValue("resetOut", 1, resetOut);
        end
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("resetOut", 1, resetOut);
        releaseCycle = cycleNum;
        @(negedge clk);
        checkValue("resetOut", 0, resetOut);
        waitForIrWrite();
        checkValue("first irWrite delay", 4, cycleNum - releaseCycle);
        lastIr = cycleNum;

        for (i = 0; i < instrCount; i++) begin
            want = expectFor(opList[i], lowList[i].rType.funct);
            repeat (4) @(negedge clk);
            checkValue("ctrl", want.word, ctrl);
            checkValue("resetOut", want.resetOut, resetOut);
            waitForIrWrite();
            checkValue("irWrite period", want.period, cycleNum - lastIr);
            lastIr = cycleNum;
        end

        errorCount += uut.ctrlChecks.failCount;
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/controlUnit_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnitChecker (
    input wire logic                 clk,
    input wire logic                 rstN,
    input wire controlPkg::ctrlWordT ctrl,
    input wire logic                 resetOut
);

    int failCount = 0;

    // A, B and ALUOut load in the cycle after the IR write
    irThenRegLoad: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.irWrite |=> ctrl.regAWrite)
        else begin
            failCount++;
            $error("regAWrite did not follow irWrite by one cycle");
        end

    noPcWithEpcWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.pcWrite && ctrl.epcWrite))
        else begin
            failCount++;
            $error("pcWrite and epcWrite were high in the same cycle");
        end

    // Registered output follows rstN one edge later
    resetHeld: assert property (@(posedge clk)
        !rstN |=> resetOut)
        else begin
            failCount++;
            $error("resetOut dropped while rstN was low");
        end

endmodule

bind controlUnit controlUnitChecker ctrlChecks (
    .clk      (clk),
    .rstN     (rstN),
    .ctrl     (ctrl),
    .resetOut (resetOut)
);

`default_nettype wire

// ==== source/controlPkg.sv ====
`default_nettype none

`include "controlUnit_macros.svh"

package controlPkg;

    typedef enum logic [5:0] {
        resetSt,
        fetchSt,
        // R-type
        addSt, andSt, multSt, divSt, jrSt, mfhiSt, mfloSt, sllSt, sllvSt,
        sltSt, sraSt, sravSt, srlSt, subSt, breakSt, rteSt, divmSt,
        // I-type
        addiSt, addiuSt, beqSt, bneSt, bleSt, bgtSt, addmSt, lbSt, lhSt,
        luiSt, lwSt, sbSt, shSt, sltiSt, swSt,
        // J-type
        jSt, jalSt,
        opcodeErrSt
    } stateT;

    typedef enum logic [2:0] {
        aluNop = 3'd0,
        aluAdd = 3'd1,
        aluSub = 3'd2
    } aluOpE;

    typedef struct packed {
        logic        memWrite;
        logic        irWrite;
        logic [2:0]  shiftReg;
        logic        regWrite;
        aluOpE       aluOp;
        logic        pcWrite;
        logic        hiWrite;
        logic        loWrite;
        logic        regAWrite;
        logic        regBWrite;
        logic        aluOutWrite;
        logic        mdrWrite;
        logic        epcWrite;
        logic [1:0]  exCause;
        logic [1:0]  pcSource;
        logic [2:0]  iorD;
        logic [1:0]  regDst;
        logic [1:0]  shiftAmt;
        logic [1:0]  shiftSrc;
        logic [2:0]  dataSrc;
        logic [1:0]  aluSrcA;
        logic [1:0]  aluSrcB;
        logic [1:0]  storeSize;
        logic [1:0]  loadSize;
    } ctrlWordT;

    typedef struct packed {
        logic [4:0]          rd;
        logic [4:0]          shamt;
        logic [`FUNCT_W-1:0] funct;
    } rTypeT;

    // Low half of the instruction word: immediate or R-type fields
    typedef union packed {
        logic [15:0] imm;
        rTypeT       rType;
    } instrLowU;

endpackage

`default_nettype wire

// ==== source/controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "controlUnit_macros.svh"

module controlUnit (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic [`OPCODE_W-1:0] opcode,
    input  controlPkg::instrLowU      instrLow,
    output controlPkg::ctrlWordT      ctrl,
    output logic                      resetOut
);

    controlPkg::stateT          decodedState;
    controlPkg::stateT          seqState;
    logic [`COUNT_W-1:0]        seqCount;

    instrDecoder decoder (
        .opcode       (opcode),
        .instrLow     (instrLow),
        .decodedState (decodedState)
    );

    cycleSequencer sequencer (
        .clk          (clk),
        .rstN         (rstN),
        .decodedState (decodedState),
        .state        (seqState),
        .count        (seqCount)
    );

    // Registered control word, aligned with the sequencer state
    controlWordGen wordGen (
        .clk      (clk),
        .rstN     (rstN),
        .state    (seqState),
        .count    (seqCount),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

endmodule

`default_nettype wire

// ==== source/controlUnit_macros.svh ====
`ifndef CONTROL_UNIT_MACROS_SVH
`define CONTROL_UNIT_MACROS_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// Cycle counter, shared by fetch and execute
`define COUNT_W 6

// Fetch cycle that writes IR and advances PC
`define FETCH_IR_CYCLE 3

// Fetch cycle that loads A, B and ALUOut
`define FETCH_REG_CYCLE 4

// Last fetch cycle, opcode and funct are decoded here
`define DECODE_CYCLE 6

`endif

// ==== source/controlWordGen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "controlUnit_macros.svh"

module controlWordGen (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  controlPkg::stateT        state,
    input  wire logic [`COUNT_W-1:0] count,
    output controlPkg::ctrlWordT     ctrl,
    output logic                     resetOut
);

    function automatic controlPkg::ctrlWordT wordFor(
        input controlPkg::stateT   st,
        input logic [`COUNT_W-1:0] cnt
    );
        controlPkg::ctrlWordT w;
        w = '0;
        case (st)
            controlPkg::resetSt: begin
                w.regWrite = 1'b1;
                w.dataSrc  = 3'd4;
            end
            controlPkg::fetchSt: begin
                if (cnt <= `COUNT_W'(`FETCH_IR_CYCLE)) begin
                    // PC + 4 on the ALU
                    w.aluOp    = controlPkg::aluAdd;
                    w.aluSrcA  = 2'd1;
                    w.aluSrcB  = 2'd1;
                    w.pcSource = 2'd1;
                    if (cnt == `COUNT_W'(`FETCH_IR_CYCLE)) begin
                        w.irWrite = 1'b1;
                        w.pcWrite = 1'b1;
                    end
                end else if (cnt == `COUNT_W'(`FETCH_REG_CYCLE)) begin
                    w.regAWrite   = 1'b1;
                    w.regBWrite   = 1'b1;
                    w.aluOutWrite = 1'b1;
                    w.aluOp       = controlPkg::aluAdd;
                    w.aluSrcA     = 2'd1;
                    w.aluSrcB     = 2'd3;
                end else if (cnt == `COUNT_W'(`DECODE_CYCLE)) begin
                    w.pcSource = 2'd1;
                end
            end
            controlPkg::breakSt: begin
                if (cnt == '0) begin
                    w.pcWrite  = 1'b1;
                    w.aluOp    = controlPkg::aluSub;
                    w.aluSrcA  = 2'd1;
                    w.aluSrcB  = 2'd1;
                    w.pcSource = 2'd1;
                end
            end
            controlPkg::rteSt: begin
                // Return through EPC
                if (cnt == '0) begin
                    w.pcWrite  = 1'b1;
                    w.pcSource = 2'd3;
                end
            end
            controlPkg::opcodeErrSt: begin
                w.epcWrite = 1'b1;
                w.exCause  = 2'd1;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl     <= wordFor(controlPkg::resetSt, '0);
            resetOut <= 1'b1;
        end else begin
            ctrl     <= wordFor(state, count);
            resetOut <= (state == controlPkg::resetSt);
        end
    end

endmodule

`default_nettype wire

// ==== source/cycleSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "controlUnit_macros.svh"

// state and count carry the pair for the coming cycle, so the
// control word registered from them lines up with stateQ/countQ
module cycleSequencer (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  controlPkg::stateT        decodedState,
    output controlPkg::stateT        state,
    output logic [`COUNT_W-1:0]      count
);

    controlPkg::stateT          stateQ;
    logic [`COUNT_W-1:0]        countQ;

    always_comb begin
        state = controlPkg::fetchSt;
        count = '0;
        case (stateQ)
            controlPkg::fetchSt: begin
                if (countQ == `COUNT_W'(`DECODE_CYCLE)) begin
                    // Jump into the instruction, count restarts
                    state = decodedState;
                    count = '0;
                end else begin
                    state = controlPkg::fetchSt;
                    count = countQ + 1'b1;
                end
            end
            // Two execute cycles
            controlPkg::breakSt,
            controlPkg::rteSt: begin
                if (countQ == '0) begin
                    state = stateQ;
                    count = countQ + 1'b1;
                end else begin
                    state = controlPkg::fetchSt;
                    count = '0;
                end
            end
            // resetSt, opcodeErrSt and the one-cycle instructions
            default: begin
                state = controlPkg::fetchSt;
                count = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stateQ <= controlPkg::resetSt;
            countQ <= '0;
        end else begin
            stateQ <= state;
            countQ <= count;
        end
    end

endmodule

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "controlUnit_macros.svh"

module instrDecoder (
    input  wire logic [`OPCODE_W-1:0] opcode,
    input  controlPkg::instrLowU      instrLow,
    output controlPkg::stateT         decodedState
);

    always_comb begin
        decodedState = controlPkg::opcodeErrSt;
        case (opcode)
            // R-type, funct selects the instruction
            6'b000000: begin
                case (instrLow.rType.funct)
                    6'b100000: decodedState = controlPkg::addSt;
                    6'b100100: decodedState = controlPkg::andSt;
                    6'b011000: decodedState = controlPkg::multSt;
                    6'b011010: decodedState = controlPkg::divSt;
                    6'b001000: decodedState = controlPkg::jrSt;
                    6'b010000: decodedState = controlPkg::mfhiSt;
                    6'b010010: decodedState = controlPkg::mfloSt;
                    6'b000000: decodedState = controlPkg::sllSt;
                    6'b000100: decodedState = controlPkg::sllvSt;
                    6'b101010: decodedState = controlPkg::sltSt;
                    6'b000011: decodedState = controlPkg::sraSt;
                    6'b000111: decodedState = controlPkg::sravSt;
                    6'b000010: decodedState = controlPkg::srlSt;
                    6'b100010: decodedState = controlPkg::subSt;
                    6'b001101: decodedState = controlPkg::breakSt;
                    6'b010011: decodedState = controlPkg::rteSt;
                    6'b000101: decodedState = controlPkg::divmSt;
                    default:   decodedState = controlPkg::opcodeErrSt;
                endcase
            end
            // I-type
            6'b001000: decodedState = controlPkg::addiSt;
            6'b001001: decodedState = controlPkg::addiuSt;
            6'b000100: decodedState = controlPkg::beqSt;
            6'b000101: decodedState = controlPkg::bneSt;
            6'b000110: decodedState = controlPkg::bleSt;
            6'b000111: decodedState = controlPkg::bgtSt;
            6'b000001: decodedState = controlPkg::addmSt;
            6'b100000: decodedState = controlPkg::lbSt;
            6'b100001: decodedState = controlPkg::lhSt;
            6'b001111: decodedState = controlPkg::luiSt;
            6'b100011: decodedState = controlPkg::lwSt;
            6'b101000: decodedState = controlPkg::sbSt;
            6'b101001: decodedState = controlPkg::shSt;
            6'b001010: decodedState = controlPkg::sltiSt;
            6'b101011: decodedState = controlPkg::swSt;
            // J-type
            6'b000010: decodedState = controlPkg::jSt;
            6'b000011: decodedState = controlPkg::jalSt;
            // All ones restarts the unit
            6'b111111: decodedState = controlPkg::resetSt;
            default:   decodedState = controlPkg::opcodeErrSt;
        endcase
    end

endmodule

`default_nettype wire
